/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := coreTestMonitor_tb
FILELIST  := coreTestMonitor.f

OBJDIR  := obj_dir
BIN     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJDIR)

/* common/coreMonPkg.sv */
`default_nettype none

`include "coreMon_macros.svh"

package coreMonPkg;

  // ----------------------------------------
  // addresses
  // ----------------------------------------
  typedef logic [`PC_BITS-1:0] pc_t;
  typedef logic [`CMP_BITS-1:0] cmpAddr_t;

  // write target of a config write
  typedef enum logic [2:0] {
    selPass    = 3'd0,
    selFail    = 3'd1,
    selFinish  = 3'd2,
    selToHost  = 3'd3,
    selFailAlt = 3'd4,
    selControl = 3'd5  // data[0] checkToHost, data[1] disableStuck, data[2] forceFail
  } tableSel_e;

  // ----------------------------------------
  // port bundles
  // ----------------------------------------
  typedef struct packed {
    logic      valid;
    tableSel_e sel;
    cmpAddr_t  data;
  } cfgWrite_t;

  typedef struct packed {
    logic valid;   // retired instruction shown
    logic commit;  // and it committed
    pc_t  pc;
  } traceBeat_t;

  typedef struct packed {
    cmpAddr_t passAddr;
    cmpAddr_t failAddr;
    cmpAddr_t finishAddr;   // zero leaves it unarmed
    cmpAddr_t toHostAddr;   // zero leaves it unarmed
    cmpAddr_t failAltAddr;  // zero leaves it unarmed
    logic     checkToHost;
    logic     disableStuck;
  } monitorCfg_t;

  typedef struct packed {
    logic passHit;
    logic failHit;
  } hits_t;

  typedef struct packed {
    logic pass;
    logic fail;
  } status_t;

endpackage

`default_nettype wire

/* common/coreMon_macros.svh */
`ifndef COREMON_MACROS_SVH
`define COREMON_MACROS_SVH

// ----------------------------------------
// trace widths
// ----------------------------------------

// full pc as shown on the trace port
`define PC_BITS 64

// low pc bits used for the table match
`define CMP_BITS 30

// ----------------------------------------
// limits and delays
// ----------------------------------------

`define STUCK_LIMIT 500     // repeated commits before the core counts as stuck
`define STUCK_CNT_BITS 10   // holds 0..STUCK_LIMIT

`define SLEEP_DELAY 20      // cycles from status latch to core reset
`define SLEEP_CNT_BITS 5    // holds 0..SLEEP_DELAY-1

`endif

/* coreTestMonitor.f */
+incdir+common
common/coreMonPkg.sv
source/monitorRegs.sv
source/pcCheck.sv
source/sleepSeq.sv
source/coreTestMonitor.sv
tb/coreTestMonitor_assert.sv
tb/coreTestMonitor_tb.sv

/* source/coreTestMonitor.sv */
`timescale 1ns/1ps
`default_nettype none

// trace monitor for one core running a self-checking test
module coreTestMonitor (
  input  wire                          clk,
  input  wire                          pcFail,
  input  wire  coreMonPkg::cfgWrite_t  cfgWr,
  input  wire  coreMonPkg::traceBeat_t trace,
  output coreMonPkg::status_t          status,
  output logic                         pcStuck,
  output logic                         coreReset
);

  coreMonPkg::monitorCfg_t cfg;
  coreMonPkg::hits_t       hits;
  logic                    forceFail;  // one-cycle command

  // ----------------------------------------
  // config table
  // ----------------------------------------
  monitorRegs regs (
    .clk       (clk),
    .pcFail    (pcFail),
    .cfgWr     (cfgWr),
    .cfg       (cfg),
    .forceFail (forceFail)
  );

  // ----------------------------------------
  // trace checks
  // ----------------------------------------
  pcCheck check (
    .clk     (clk),
    .pcFail  (pcFail),
    .trace   (trace),
    .cfg     (cfg),
    .hits    (hits),
    .pcStuck (pcStuck)
  );

  // status and core sleep
  sleepSeq seq (
    .clk       (clk),
    .pcFail    (pcFail),
    .hits      (hits),
    .forceFail (forceFail),
    .cfg       (cfg),
    .status    (status),
    .coreReset (coreReset)
  );

endmodule

`default_nettype wire

/* source/monitorRegs.sv */
`timescale 1ns/1ps
`default_nettype none

// address table and control bits, written one entry per cycle
module monitorRegs (
  input  wire                          clk,
  input  wire                          pcFail,
  input  wire  coreMonPkg::cfgWrite_t  cfgWr,
  output coreMonPkg::monitorCfg_t      cfg,
  output logic                         forceFail
);

  logic tableWr;  // one of the five address entries
  logic ctrlWr;   // control word

  always_comb begin
    tableWr = cfgWr.valid && (cfgWr.sel != coreMonPkg::selControl);
    ctrlWr  = cfgWr.valid && (cfgWr.sel == coreMonPkg::selControl);
  end

  // ----------------------------------------
  // address entries
  // ----------------------------------------
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      cfg.passAddr    <= '0;
      cfg.failAddr    <= '0;
      cfg.finishAddr  <= '0;
      cfg.toHostAddr  <= '0;
      cfg.failAltAddr <= '0;
    end else if (tableWr) begin
      case (cfgWr.sel)
        coreMonPkg::selPass:    cfg.passAddr    <= cfgWr.data;
        coreMonPkg::selFail:    cfg.failAddr    <= cfgWr.data;
        coreMonPkg::selFinish:  cfg.finishAddr  <= cfgWr.data;
        coreMonPkg::selToHost:  cfg.toHostAddr  <= cfgWr.data;
        coreMonPkg::selFailAlt: cfg.failAltAddr <= cfgWr.data;
        default: begin
          // unused codes are dropped
        end
      endcase
    end
  end

  // ----------------------------------------
  // control bits
  // ----------------------------------------

  // levels, held until rewritten or reset
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      cfg.checkToHost  <= 1'b0;
      cfg.disableStuck <= 1'b0;
    end else if (ctrlWr) begin
      cfg.checkToHost  <= cfgWr.data[0];
      cfg.disableStuck <= cfgWr.data[1];
    end
  end

  // force-fail is a command, not a level
  // high for exactly the cycle after the write
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      forceFail <= 1'b0;
    end else begin
      forceFail <= ctrlWr && cfgWr.data[2];  // self-clears next cycle
    end
  end

endmodule

`default_nettype wire

/* source/pcCheck.sv */
`timescale 1ns/1ps
`default_nettype none

`include "coreMon_macros.svh"

// table compare on the trace pc plus the stuck-pc counter
module pcCheck (
  input  wire                            clk,
  input  wire                            pcFail,
  input  wire  coreMonPkg::traceBeat_t   trace,
  input  wire  coreMonPkg::monitorCfg_t  cfg,
  output coreMonPkg::hits_t              hits,
  output logic                           pcStuck
);

  localparam logic [`STUCK_CNT_BITS-1:0] stuckLimit = `STUCK_LIMIT;

  coreMonPkg::cmpAddr_t cmpPc;
  logic passMatch;
  logic failMatch;
  logic passMatchQ;  // compare stage
  logic failMatchQ;

  coreMonPkg::pc_t lastPc;  // last committed pc
  logic [`STUCK_CNT_BITS-1:0] stuckCnt;

  // ----------------------------------------
  // address compare
  // ----------------------------------------
  always_comb begin
    cmpPc = trace.pc[`CMP_BITS-1:0];

    // pass entry is always armed, the others only when nonzero
    passMatch = trace.valid && (
        (cmpPc == cfg.passAddr) ||
        ((cfg.finishAddr != '0) && (cmpPc == cfg.finishAddr)) ||
        ((cfg.toHostAddr != '0) && cfg.checkToHost && (cmpPc == cfg.toHostAddr)));

    failMatch = trace.valid && (
        (cmpPc == cfg.failAddr) ||
        ((cfg.failAltAddr != '0) && (cmpPc == cfg.failAltAddr)));
  end

  // two stages, compare then merge with stuck
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      passMatchQ <= 1'b0;
      failMatchQ <= 1'b0;
      hits       <= '0;
    end else begin
      passMatchQ   <= passMatch;
      failMatchQ   <= failMatch;
      hits.passHit <= passMatchQ;
      hits.failHit <= failMatchQ || pcStuck;  // stuck core counts as a fail
    end
  end

  // ----------------------------------------
  // stuck detector
  // ----------------------------------------
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      lastPc   <= '0;
      stuckCnt <= '0;
    end else if (trace.valid && trace.commit) begin
      lastPc <= trace.pc;
      if (trace.pc != lastPc) begin
        stuckCnt <= '0;  // moved on
      end else if (stuckCnt != stuckLimit) begin
        stuckCnt <= stuckCnt + 1'b1;
      end
    end
  end

  always_comb begin
    pcStuck = (stuckCnt == stuckLimit) && !cfg.disableStuck;
  end

endmodule

`default_nettype wire

/* source/sleepSeq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "coreMon_macros.svh"

// latches the first pass/fail and puts the core to sleep after a delay
module sleepSeq (
  input  wire                            clk,
  input  wire                            pcFail,
  input  wire  coreMonPkg::hits_t        hits,
  input  wire                            forceFail,
  input  wire  coreMonPkg::monitorCfg_t  cfg,
  output coreMonPkg::status_t            status,
  output logic                           coreReset
);

  localparam logic [`SLEEP_CNT_BITS-1:0] lastTick = `SLEEP_DELAY - 1;

  logic anyHit;
  logic firstHit;  // first detection wins
  logic sleeping;  // delay running
  logic [`SLEEP_CNT_BITS-1:0] delayCnt;

  always_comb begin
    anyHit   = hits.passHit || hits.failHit;
    firstHit = anyHit && (status == '0) && !coreReset;
  end

  // ----------------------------------------
  // status latch
  // ----------------------------------------
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      status <= '0;
    end else if (forceFail) begin
      status.pass <= 1'b0;  // overrides any earlier pass
      status.fail <= 1'b1;
    end else if (firstHit) begin
      status.pass <= hits.passHit;
      status.fail <= hits.failHit;
    end
  end

  // ----------------------------------------
  // sleep delay
  // ----------------------------------------

  // coreReset sticks until the next reset
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      sleeping  <= 1'b0;
      delayCnt  <= '0;
      coreReset <= 1'b0;
    end else if (sleeping) begin
      if (delayCnt == lastTick) begin
        sleeping  <= 1'b0;
        coreReset <= 1'b1;
      end else begin
        delayCnt <= delayCnt + 1'b1;
      end
    end else if (firstHit && !cfg.disableStuck) begin
      sleeping <= 1'b1;  // core keeps running when stuck checks are off
      delayCnt <= '0;
    end
  end

endmodule

`default_nettype wire

/* tb/coreTestMonitor_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "coreMon_macros.svh"

// timing and hit rules of the monitor bound into the top level
module coreTestMonitor_assert (
  input wire                          clk,
  input wire                          pcFail,
  input wire coreMonPkg::cfgWrite_t   cfgWr,
  input wire coreMonPkg::traceBeat_t  trace,
  input wire coreMonPkg::monitorCfg_t cfg,
  input wire coreMonPkg::hits_t       hits,
  input wire                          forceFail,
  input wire coreMonPkg::status_t     status,
  input wire                          pcStuck,
  input wire                          coreReset
);

  int unsigned failCount = 0;  // count of failed assertions

  logic [`CMP_BITS-1:0] lowPc;
  logic passArmed;  // beat hits an armed pass-type entry
  logic failArmed;

  always_comb begin
    lowPc = trace.pc[`CMP_BITS-1:0];
    passArmed = trace.valid && ((lowPc == cfg.passAddr) ||
        (cfg.finishAddr != 0 && lowPc == cfg.finishAddr) ||
        (cfg.checkToHost && cfg.toHostAddr != 0 && lowPc == cfg.toHostAddr));
    failArmed = trace.valid && ((lowPc == cfg.failAddr) ||
        (cfg.failAltAddr != 0 && lowPc == cfg.failAltAddr));
  end

  // ----------------------------------------
  // reset and hit rules
  // ----------------------------------------
  resetLow: assert property (@(posedge clk)
      pcFail |-> (status == '0) && !pcStuck && !coreReset)
    else begin failCount++; $error("outputs not low in reset"); end

  passHitRule: assert property (@(posedge clk) disable iff (pcFail)
      1'b1 |-> ##2 (hits.passHit == $past(passArmed, 2)))
    else begin failCount++; $error("passHit does not follow the armed entries"); end

  failHitRule: assert property (@(posedge clk) disable iff (pcFail)
      failArmed |-> ##2 hits.failHit)
    else begin failCount++; $error("fail entry beat gave no failHit"); end

  passLatch: assert property (@(posedge clk) disable iff (pcFail)
      passArmed && !failArmed && status == '0 && hits == '0 && !coreReset && !pcStuck
      |-> ##3 status.pass)
    else begin failCount++; $error("pass beat did not latch status.pass"); end

  failLatch: assert property (@(posedge clk) disable iff (pcFail)
      failArmed && status == '0 && hits == '0 && !coreReset |-> ##3 status.fail)
    else begin failCount++; $error("fail beat did not latch status.fail"); end

  // ----------------------------------------
  // stuck, sleep and force fail
  // ----------------------------------------
  stuckFail: assert property (@(posedge clk) disable iff (pcFail)
      pcStuck && status == '0 && hits == '0 && !coreReset |-> ##2 status.fail)
    else begin failCount++; $error("pcStuck did not latch status.fail"); end

  sleepDelay: assert property (@(posedge clk) disable iff (pcFail)
      $rose(status != '0) && !$past(forceFail) && !$past(cfg.disableStuck)
      |-> ##(`SLEEP_DELAY) $rose(coreReset))
    else begin failCount++; $error("coreReset not raised after the sleep delay"); end

  noSleep: assert property (@(posedge clk) disable iff (pcFail)
      cfg.disableStuck && !coreReset |=> !coreReset)
    else begin failCount++; $error("coreReset rose with stuck check disabled"); end

  sleepHold: assert property (@(posedge clk) disable iff (pcFail)
      coreReset |=> coreReset)
    else begin failCount++; $error("coreReset dropped before reset"); end

  forceWrite: assert property (@(posedge clk) disable iff (pcFail)
      cfgWr.valid && cfgWr.sel == coreMonPkg::selControl && cfgWr.data[2]
      |-> ##2 status.fail && !status.pass)
    else begin failCount++; $error("force-fail write did not set status.fail"); end

endmodule

bind coreTestMonitor coreTestMonitor_assert chk (
  .clk       (clk),
  .pcFail    (pcFail),
  .cfgWr     (cfgWr),
  .trace     (trace),
  .cfg       (cfg),
  .hits      (hits),
  .forceFail (forceFail),
  .status    (status),
  .pcStuck   (pcStuck),
  .coreReset (coreReset)
);

`default_nettype wire

/* tb/coreTestMonitor_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "coreMon_macros.svh"

module coreTestMonitor_tb;

  localparam int period = 40;

  // stuck and disable runs dominate the run time
  localparam int testCycles = 601 + 2 * (`STUCK_LIMIT + 20) + 8 * (`SLEEP_DELAY + 10);
  localparam int watchCycles = 2 * testCycles;  // margin for resets and table loads

  localparam logic [29:0] passPc   = 30'h100;
  localparam logic [29:0] failPc   = 30'h200;
  localparam logic [29:0] altPc    = 30'h300;
  localparam logic [29:0] toHostPc = 30'h400;

  logic clk;
  logic pcFail;
  coreMonPkg::cfgWrite_t  cfgWr;
  coreMonPkg::traceBeat_t trace;
  coreMonPkg::status_t    status;
  logic pcStuck;
  logic coreReset;

  logic [31:0] rngState = 32'h2b79_716f;
  int testsRun = 0;
  int testsMissed = 0;

  coreTestMonitor dut_i (
    .clk       (clk),
    .pcFail    (pcFail),
    .cfgWr     (cfgWr),
    .trace     (trace),
    .status    (status),
    .pcStuck   (pcStuck),
    .coreReset (coreReset)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // random pc that can never hit a table entry
  task automatic nextFiller(output coreMonPkg::pc_t pc);
    rngState = xorshift(rngState);
    pc = {rngState, rngState ^ 32'h5a5a_0f0f};
    pc[29:28] = 2'b11;  // table entries live far below
  endtask

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic idle(input int n);
    trace = '0;
    cfgWr = '0;
    repeat (n) tick();
  endtask

  task automatic applyReset();
    pcFail = 1'b1;
    idle(5);
    pcFail = 1'b0;
    tick();
  endtask

  task automatic writeCfg(input coreMonPkg::tableSel_e sel, input logic [29:0] data);
    cfgWr = '{valid: 1'b1, sel: sel, data: data};
    tick();
    cfgWr = '0;
  endtask

  task automatic loadTable();
    writeCfg(coreMonPkg::selPass, passPc);
    writeCfg(coreMonPkg::selFail, failPc);
    writeCfg(coreMonPkg::selFailAlt, altPc);
    writeCfg(coreMonPkg::selToHost, toHostPc);
  endtask

  task automatic sendBeat(input coreMonPkg::pc_t pc, input logic commit);
    trace = '{valid: 1'b1, commit: commit, pc: pc};
    tick();
    trace = '0;
  endtask

  task automatic sendFillers(input int n);
    coreMonPkg::pc_t pc;
    repeat (n) begin
      nextFiller(pc);
      sendBeat(pc, 1'b1);
    end
  endtask

  // waits up to maxCycles for status to reach want
  task automatic waitStatus(input coreMonPkg::status_t want, input int maxCycles,
                            output bit seen);
    int n;
    n = 0;
    seen = 1'b0;
    while (n < maxCycles && !seen) begin
      if (status == want) seen = 1'b1;
      else tick();
      n++;
    end
  endtask

  task automatic endTest(input string name, input bit ok, input string missed);
    testsRun++;
    if (ok) begin
      $display("test %0d %s done", testsRun, name);
    end else begin
      testsMissed++;
      $display("test %0d %s: %s", testsRun, name, missed);
    end
  endtask

  // ----------------------------------------
  // watchdog
  // ----------------------------------------
  initial begin
    #(watchCycles * period);
    $display("watchdog expired, tests did not finish");
    $display("TB FAILED");
    $finish;
  end

  // ----------------------------------------
  // tests
  // ----------------------------------------
  initial begin
    bit seen;
    bit flag;
    int n;
    coreMonPkg::pc_t pc;

    pcFail = 1'b1;
    cfgWr = '0;
    trace = '0;

    // reset state
    applyReset();
    endTest("reset", status == '0 && !pcStuck && !coreReset, "outputs not low after reset");

    // pass and sleep
    loadTable();
    sendFillers(8);
    sendBeat({34'h0, passPc}, 1'b1);
    n = 1;
    while (!coreReset && n < `SLEEP_DELAY + 10) begin
      tick();
      n++;
    end
    idle(5);
    endTest("pass and sleep", status.pass && coreReset, "coreReset never rose after pass");

    // fail entries and arming
    applyReset();
    loadTable();
    sendBeat({34'h0, altPc}, 1'b1);
    waitStatus('{pass: 1'b0, fail: 1'b1}, 10, seen);
    flag = seen;
    applyReset();
    loadTable();
    sendBeat({34'h0, toHostPc}, 1'b1);
    sendBeat('0, 1'b1);  // finish entry left at zero
    idle(6);
    flag = flag && (status == '0);
    writeCfg(coreMonPkg::selControl, 30'h1);
    sendBeat({34'h0, toHostPc}, 1'b1);
    waitStatus('{pass: 1'b1, fail: 1'b0}, 10, seen);
    flag = flag && seen;
    applyReset();
    loadTable();
    sendBeat({34'h0, failPc}, 1'b1);
    waitStatus('{pass: 1'b0, fail: 1'b1}, 10, seen);
    endTest("fail and arming", flag && seen, "a table entry did not behave as armed");

    // stuck detection
    applyReset();
    loadTable();
    nextFiller(pc);
    repeat (300) sendBeat(pc, 1'b1);
    sendFillers(1);  // breaks the run
    flag = 1'b1;
    for (int i = 0; i < 300; i++) begin
      sendBeat(pc, 1'b1);
      if (pcStuck) flag = 1'b0;
    end
    n = 0;
    while (!pcStuck && n < `STUCK_LIMIT + 20) begin
      sendBeat(pc, 1'b1);
      n++;
    end
    flag = flag && pcStuck;
    waitStatus('{pass: 1'b0, fail: 1'b1}, 10, seen);
    endTest("stuck", flag && seen, "pcStuck did not follow the repeat count");

    // disable stuck
    applyReset();
    loadTable();
    writeCfg(coreMonPkg::selControl, 30'h2);
    nextFiller(pc);
    flag = 1'b1;
    repeat (`STUCK_LIMIT + 20) begin
      sendBeat(pc, 1'b1);
      if (pcStuck) flag = 1'b0;
    end
    sendBeat({34'h0, passPc}, 1'b1);
    waitStatus('{pass: 1'b1, fail: 1'b0}, 10, seen);
    idle(`SLEEP_DELAY + 10);
    endTest("disable stuck", flag && seen && !coreReset, "core was put to sleep");

    // force fail after pass
    applyReset();
    loadTable();
    sendBeat({34'h0, passPc}, 1'b1);
    waitStatus('{pass: 1'b1, fail: 1'b0}, 10, flag);
    writeCfg(coreMonPkg::selControl, 30'h4);
    waitStatus('{pass: 1'b0, fail: 1'b1}, 3, seen);
    endTest("force fail", flag && seen, "force fail did not set status.fail");

    idle(2);
    $display("tests %0d, missed %0d, assertion failures %0d",
             testsRun, testsMissed, dut_i.chk.failCount);
    if (testsMissed == 0 && dut_i.chk.failCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
